/* src.f */
verilog/fetch_pkg.sv
verilog/fetch_target_mux.sv
verilog/prefetch_buffer.sv
verilog/offset_fsm.sv
verilog/compressed_expander.sv
verilog/if_stage.sv
testbench/tb_clock_gen.sv
testbench/if_stage_props.sv
testbench/tb_if_stage.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_if_stage -o sim_if_stage

out=$(./obj_dir/sim_if_stage)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
  exit 0
else
  exit 1
fi

/* testbench/tb_if_stage.sv */
`default_nettype none

module tb_if_stage;

  localparam int unsigned DEPTH = 2;
  localparam int unsigned PHASES = 4;
  localparam int unsigned TIMEOUT = 400 * PHASES;
  localparam int unsigned PHASE_INSNS = 60;

  logic                  clk;
  logic                  rst_n;
  fetch_pkg::addr_t      boot_addr_i;
  logic                  req_i;
  logic                  stall_if_i;
  logic                  stall_id_i;
  logic                  redirect_i;
  fetch_pkg::pc_sel_e    pc_sel_i;
  fetch_pkg::exc_cause_e exc_cause_i;
  fetch_pkg::addr_t      jump_target_i;
  fetch_pkg::addr_t      epc_i;
  logic                  instr_req_o;
  fetch_pkg::addr_t      instr_addr_o;
  logic                  instr_gnt_i;
  logic                  instr_rvalid_i;
  fetch_pkg::word_t      instr_rdata_i;
  logic                  valid_o;
  fetch_pkg::addr_t      current_pc_if_o;
  fetch_pkg::id_instr_t  id_o;
  logic                  if_busy_o;

  integer seed = 32'h1ec4;
  int unsigned cycle_cnt = 0;
  int unsigned tick = 0;

  // memory response queue holding address and earliest answer tick
  fetch_pkg::addr_t resp_addr_q[$];
  int unsigned      resp_due_q[$];

  // reference model state
  fetch_pkg::addr_t     model_pc;
  logic                 started = 1'b0;
  logic                 hold_pending = 1'b0;
  int unsigned          consumed = 0;
  int unsigned          ill_cnt = 0;
  // snapshot of the last sampled cycle for the IF/ID check
  logic                 have_prev = 1'b0;
  logic                 prev_stall_id;
  logic                 prev_valid;
  fetch_pkg::addr_t     prev_pc;
  logic [32:0]          prev_exp;
  fetch_pkg::id_instr_t prev_id;

  tb_clock_gen tb_clock_gen_i (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  if_stage #(
    .DEPTH(DEPTH)
  ) if_stage_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .boot_addr_i    (boot_addr_i),
    .req_i          (req_i),
    .stall_if_i     (stall_if_i),
    .stall_id_i     (stall_id_i),
    .redirect_i     (redirect_i),
    .pc_sel_i       (pc_sel_i),
    .exc_cause_i    (exc_cause_i),
    .jump_target_i  (jump_target_i),
    .epc_i          (epc_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .valid_o        (valid_o),
    .current_pc_if_o(current_pc_if_o),
    .id_o           (id_o),
    .if_busy_o      (if_busy_o)
  );

  ////////////////////////////////////////////////////////////
  // program image and reference expansion
  ////////////////////////////////////////////////////////////

  // one half-word per half address with its class picked by a hash
  function automatic logic [15:0] half_at(input fetch_pkg::addr_t a);
    logic [31:0] h;
    h = (a ^ 32'h5bd1_e995) * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    case (h[2:0])
      3'd0, 3'd1, 3'd2: return {h[31:18], 2'b11};
      3'd3:             return {3'b000, h[28:18], 2'b01};
      3'd4:             return {3'b010, h[28:18], 2'b01};
      3'd5:             return {3'b101, h[28:18], 2'b01};
      // c.add or c.mv with a nonzero rs2
      3'd6:             return {3'b100, h[20], h[27:23], h[31:28], 1'b1, 2'b10};
      default:          return {h[29:16], 2'b00};
    endcase
  endfunction

  function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t w);
    return {half_at(w + 32'd2), half_at(w)};
  endfunction

  // raw instruction at a PC with compressed ones zero-extended
  function automatic fetch_pkg::word_t raw_at(input fetch_pkg::addr_t pc);
    logic [15:0] lo;
    lo = half_at(pc);
    if (lo[1:0] == 2'b11) begin
      return {half_at(pc + 32'd2), lo};
    end
    return {16'h0000, lo};
  endfunction

  // returns {illegal, expanded instruction}
  function automatic logic [32:0] expand_ref(input fetch_pkg::word_t raw);
    logic [15:0] c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] simm;
    logic [20:0] off;
    c    = raw[15:0];
    rd   = c[11:7];
    rs2  = c[6:2];
    simm = {{6{c[12]}}, c[12], c[6:2]};
    off  = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    if (raw[1:0] == 2'b11) begin
      return {1'b0, raw};
    end
    if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
      return {1'b0, simm, rd, 3'b000, rd, 7'h13};
    end
    if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
      return {1'b0, simm, 5'd0, 3'b000, rd, 7'h13};
    end
    if (c[1:0] == 2'b01 && c[15:13] == 3'b101) begin
      return {1'b0, off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
    end
    if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && rs2 != 5'd0) begin
      if (c[12]) begin
        return {1'b0, 7'd0, rs2, rd, 3'b000, rd, 7'h33};
      end
      return {1'b0, 7'd0, rs2, 5'd0, 3'b000, rd, 7'h33};
    end
    // unsupported encodings pass on as they came
    return {1'b1, raw};
  endfunction

  // expected PC after a redirect
  function automatic fetch_pkg::addr_t redirect_target();
    case (pc_sel_i)
      fetch_pkg::PC_JUMP: return {jump_target_i[31:1], 1'b0};
      fetch_pkg::PC_ERET: return {epc_i[31:1], 1'b0};
      fetch_pkg::PC_EXCEPTION: begin
        case (exc_cause_i)
          fetch_pkg::EXC_ILLINSN: return {boot_addr_i[31:5], 5'h10};
          fetch_pkg::EXC_IRQ:     return {boot_addr_i[31:5], 5'h08};
          fetch_pkg::EXC_IRQ_NM:  return {boot_addr_i[31:5], 5'h0c};
          default:                return {boot_addr_i[31:5], 5'h00};
        endcase
      end
      default: return {boot_addr_i[31:5], 5'h00};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // checks and run control
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  // random grant and in-order answers with random latency
  task automatic drive_memory();
    logic [31:0] r;
    r = $random(seed);
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = $random(seed);
    if (resp_addr_q.size() != 0 && resp_due_q[0] <= tick && r[0]) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = mem_word(resp_addr_q.pop_front());
      void'(resp_due_q.pop_front());
    end
    instr_gnt_i = instr_req_o && (r[2:1] != 2'b00);
    if (instr_gnt_i) begin
      resp_addr_q.push_back(instr_addr_o);
      resp_due_q.push_back(tick + 1 + 32'(r[4:3]));
    end
  endtask

  // IF/ID register against the previous sampled cycle
  task automatic check_id();
    if (have_prev) begin
      if (prev_stall_id) begin
        check_eq("held id_o.instr", id_o.instr, prev_id.instr);
        check_eq("held id_o.pc", id_o.pc, prev_id.pc);
        check_eq("held id_o.illegal_c", 32'(id_o.illegal_c), 32'(prev_id.illegal_c));
      end else begin
        check_eq("id_o.pc", id_o.pc, prev_pc);
        if (prev_valid) begin
          check_eq("id_o.instr", id_o.instr, prev_exp[31:0]);
          check_eq("id_o.illegal_c", 32'(id_o.illegal_c), 32'(prev_exp[32]));
          if (prev_exp[32]) begin
            ill_cnt++;
          end
        end
      end
    end
  endtask

  task automatic step(input int phase);
    logic [31:0] r;
    logic [31:0] r2;
    logic [32:0] e;
    logic [15:0] lo;
    logic        take;
    @(negedge clk);
    tick++;
    check_id();
    // granted requests not yet answered keep the stage busy
    check_eq("if_busy_o", 32'(if_busy_o), 32'(resp_addr_q.size() != 0));
    drive_memory();
    r  = $random(seed);
    r2 = $random(seed);
    e  = '0;
    redirect_i = 1'b0;
    if (phase == 0) begin
      req_i = 1'b0;
    end else if (!started) begin
      // first request branches to the boot vector
      req_i    = 1'b1;
      started  = 1'b1;
      model_pc = {boot_addr_i[31:5], 5'h00};
    end else begin
      req_i         = (phase == 3) ? (r[2:0] != 3'd0) : 1'b1;
      stall_if_i    = (phase == 3) && (r[4:3] == 2'd0);
      stall_id_i    = (phase == 3) && (r[6:5] == 2'd0);
      redirect_i    = (phase >= 2) && (r[11:8] == 4'd0);
      pc_sel_i      = fetch_pkg::pc_sel_e'(r[13:12]);
      exc_cause_i   = fetch_pkg::exc_cause_e'(r[15:14]);
      jump_target_i = {16'h0000, r2[15:1], 1'b0};
      epc_i         = {16'h0000, r2[31:17], 1'b0};
    end
    #10;
    if (phase == 0) begin
      check_eq("valid_o before start", 32'(valid_o), 32'd0);
      check_eq("instr_req_o before start", 32'(instr_req_o), 32'd0);
    end else if (redirect_i) begin
      check_eq("valid_o in redirect cycle", 32'(valid_o), 32'd0);
      model_pc     = redirect_target();
      hold_pending = 1'b0;
    end else begin
      if (hold_pending) begin
        check_eq("valid_o held under stall", 32'(valid_o), 32'd1);
      end
      hold_pending = 1'b0;
      if (valid_o) begin
        check_eq("current_pc_if_o", current_pc_if_o, model_pc);
        e    = expand_ref(raw_at(model_pc));
        lo   = half_at(model_pc);
        take = req_i && !stall_if_i;
        if (take) begin
          model_pc = model_pc + ((lo[1:0] == 2'b11) ? 32'd4 : 32'd2);
          consumed++;
        end
        hold_pending = !take;
      end
    end
    prev_stall_id = stall_id_i;
    prev_valid    = valid_o;
    prev_pc       = current_pc_if_o;
    prev_exp      = e;
    prev_id       = id_o;
    have_prev     = 1'b1;
  endtask

  task automatic run_phase(input int phase, input int unsigned n);
    int unsigned start;
    start = consumed;
    while (consumed - start < n) begin
      step(phase);
    end
  endtask

  initial begin
    boot_addr_i    = 32'h0000_1a3c;
    req_i          = 1'b0;
    stall_if_i     = 1'b0;
    stall_id_i     = 1'b0;
    redirect_i     = 1'b0;
    pc_sel_i       = fetch_pkg::PC_BOOT;
    exc_cause_i    = fetch_pkg::EXC_RESET;
    jump_target_i  = '0;
    epc_i          = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    @(posedge rst_n);
    // idle, then plain flow, redirects, and redirects with stalls
    repeat (20) step(0);
    run_phase(1, PHASE_INSNS);
    run_phase(2, PHASE_INSNS);
    run_phase(3, PHASE_INSNS);
    check_eq("illegal compressed seen", 32'(ill_cnt != 0), 32'd1);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/if_stage_props.sv */
`default_nettype none

module if_stage_props #(
  parameter int unsigned DEPTH = 2
) (
  input wire logic                     clk,
  input wire logic                     rst_n,
  input wire logic                     instr_req_o,
  input wire fetch_pkg::addr_t         instr_addr_o,
  input wire logic                     instr_gnt_i,
  input wire logic                     instr_rvalid_i,
  input wire logic                     redirect_i,
  input wire logic                     valid_o,
  input wire logic                     if_busy_o,
  input wire fetch_pkg::offset_state_e state_i
);

  // granted requests still waiting for their response
  int unsigned pend_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 0;
    end else begin
      pend_q <= pend_q + 32'(instr_req_o && instr_gnt_i) - 32'(instr_rvalid_i);
    end
  end

  // request and address hold until granted
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && (instr_addr_o == $past(instr_addr_o)))
    else $error("instr_addr_o changed while waiting for grant");

  // every response belongs to a grant, within the depth
  rvalid_limit: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (pend_q != 0) && (pend_q <= DEPTH))
    else $error("instr_rvalid_i beyond the outstanding limit");

  no_valid_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_i |-> !valid_o)
    else $error("valid_o high in a redirect cycle");

  // quiet outputs and idle FSM while in reset
  reset_state: assert property (@(posedge clk)
    !rst_n |-> !instr_req_o && !valid_o && !if_busy_o && (state_i == fetch_pkg::IDLE))
    else $error("outputs or FSM not idle during reset");

endmodule

bind if_stage if_stage_props #(
  .DEPTH(DEPTH)
) if_stage_props_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .instr_req_o   (instr_req_o),
  .instr_addr_o  (instr_addr_o),
  .instr_gnt_i   (instr_gnt_i),
  .instr_rvalid_i(instr_rvalid_i),
  .redirect_i    (redirect_i),
  .valid_o       (valid_o),
  .if_busy_o     (if_busy_o),
  .state_i       (offset_fsm_i.state_q)
);

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // period of 100, reset held for 16 cycles
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/if_stage.sv */
`default_nettype none

module if_stage #(
  parameter int unsigned DEPTH = 2
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire fetch_pkg::addr_t      boot_addr_i,
  input  wire logic                  req_i,
  input  wire logic                  stall_if_i,
  input  wire logic                  stall_id_i,
  input  wire logic                  redirect_i,
  input  wire fetch_pkg::pc_sel_e    pc_sel_i,
  input  wire fetch_pkg::exc_cause_e exc_cause_i,
  input  wire fetch_pkg::addr_t      jump_target_i,
  input  wire fetch_pkg::addr_t      epc_i,
  output logic                       instr_req_o,
  output fetch_pkg::addr_t           instr_addr_o,
  input  wire logic                  instr_gnt_i,
  input  wire logic                  instr_rvalid_i,
  input  wire fetch_pkg::word_t      instr_rdata_i,
  output logic                       valid_o,
  output fetch_pkg::addr_t           current_pc_if_o,
  output fetch_pkg::id_instr_t       id_o,
  output logic                       if_busy_o
);

  fetch_pkg::redirect_t   target;
  fetch_pkg::fetch_word_t head;
  logic                   next_valid;
  fetch_pkg::word_t       next_rdata;
  logic                   pop;
  logic                   branch;
  fetch_pkg::word_t       instr_sel;
  fetch_pkg::word_t       instr_exp;
  logic                   illegal_c;

  ////////////////////////////////////////////////////////////
  // fetch path
  ////////////////////////////////////////////////////////////

  fetch_target_mux fetch_target_mux_i (
    .boot_addr_i  (boot_addr_i),
    .pc_sel_i     (pc_sel_i),
    .exc_cause_i  (exc_cause_i),
    .jump_target_i(jump_target_i),
    .epc_i        (epc_i),
    .redirect_i   (redirect_i),
    .target_o     (target)
  );

  // flush and restart on every branch of the FSM
  prefetch_buffer #(
    .DEPTH(DEPTH)
  ) prefetch_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (target.addr),
    .pop_i         (pop),
    .head_o        (head),
    .next_valid_o  (next_valid),
    .next_rdata_o  (next_rdata),
    .busy_o        (if_busy_o),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i)
  );

  offset_fsm offset_fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .stall_if_i  (stall_if_i),
    .redirect_i  (target),
    .head_i      (head),
    .next_valid_i(next_valid),
    .next_rdata_i(next_rdata),
    .valid_o     (valid_o),
    .pc_o        (current_pc_if_o),
    .instr_o     (instr_sel),
    .pop_o       (pop),
    .branch_o    (branch)
  );

  compressed_expander compressed_expander_i (
    .instr_i  (instr_sel),
    .instr_o  (instr_exp),
    .illegal_o(illegal_c)
  );

  ////////////////////////////////////////////////////////////
  // IF/ID register, frozen while ID stalls
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_o <= '0;
    end else if (!stall_id_i) begin
      id_o.instr     <= instr_exp;
      id_o.pc        <= current_pc_if_o;
      id_o.illegal_c <= illegal_c;
    end
  end

endmodule

`default_nettype wire

/* verilog/compressed_expander.sv */
`default_nettype none

module compressed_expander (
  input  wire fetch_pkg::word_t instr_i,
  output fetch_pkg::word_t      instr_o,
  output logic                  illegal_o
);

  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm6;
  logic [2:0]  funct3;

  assign rd     = instr_i[11:7];
  assign rs2    = instr_i[6:2];
  assign funct3 = instr_i[15:13];
  // 6-bit signed immediate of C.ADDI and C.LI
  assign imm6   = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

  always_comb begin
    // unsupported encodings pass through unchanged
    instr_o   = instr_i;
    illegal_o = (instr_i[1:0] != 2'b11);
    unique case (instr_i[1:0])
      2'b01: begin
        unique case (funct3)
          3'b000: begin
            // c.addi -> addi rd, rd, imm
            instr_o   = {imm6, rd, 3'b000, rd, 7'b0010011};
            illegal_o = 1'b0;
          end
          3'b010: begin
            // c.li -> addi rd, x0, imm
            instr_o   = {imm6, 5'b00000, 3'b000, rd, 7'b0010011};
            illegal_o = 1'b0;
          end
          3'b101: begin
            // c.j -> jal x0, offset
            instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                       instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
                       {9{instr_i[12]}}, 5'b00000, 7'b1101111};
            illegal_o = 1'b0;
          end
          default: begin
          end
        endcase
      end
      2'b10: begin
        // rs2 of zero would be c.jr, c.jalr or c.ebreak
        if ((funct3 == 3'b100) && (rs2 != 5'b00000)) begin
          if (instr_i[12]) begin
            // c.add -> add rd, rd, rs2
            instr_o = {7'b0000000, rs2, rd, 3'b000, rd, 7'b0110011};
          end else begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'b0000000, rs2, 5'b00000, 3'b000, rd, 7'b0110011};
          end
          illegal_o = 1'b0;
        end
      end
      default: begin
        // quadrant 0 unsupported, 2'b11 is a full instruction
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/offset_fsm.sv */
`default_nettype none

module offset_fsm (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   req_i,
  input  wire logic                   stall_if_i,
  input  wire fetch_pkg::redirect_t   redirect_i,
  input  wire fetch_pkg::fetch_word_t head_i,
  input  wire logic                   next_valid_i,
  input  wire fetch_pkg::word_t       next_rdata_i,
  output logic                        valid_o,
  output fetch_pkg::addr_t            pc_o,
  output fetch_pkg::word_t            instr_o,
  output logic                        pop_o,
  output logic                        branch_o
);

  fetch_pkg::offset_state_e state_q;
  fetch_pkg::offset_state_e state_d;
  fetch_pkg::half_t         lo_half;
  fetch_pkg::half_t         hi_half;
  logic                     unaligned;
  logic                     consume;

  assign lo_half = head_i.rdata[15:0];
  assign hi_half = head_i.rdata[31:16];
  assign consume = req_i && !stall_if_i;

  ////////////////////////////////////////////////////////////
  // instruction and PC selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    pc_o = {head_i.addr[31:2], unaligned, 1'b0};
    if (!unaligned) begin
      // compressed halves go out zero-extended
      instr_o = (lo_half[1:0] != 2'b11) ? {16'h0000, lo_half} : head_i.rdata;
    end else if (hi_half[1:0] != 2'b11) begin
      instr_o = {16'h0000, hi_half};
    end else begin
      // straddling word, upper part from the next buffer entry
      instr_o = {next_rdata_i[15:0], hi_half};
    end
  end

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    valid_o   = 1'b0;
    pop_o     = 1'b0;
    branch_o  = 1'b0;
    unaligned = 1'b0;
    unique case (state_q)
      fetch_pkg::IDLE: begin
        // start at the boot vector
        if (req_i) begin
          branch_o = 1'b1;
          state_d  = fetch_pkg::WAIT_ALIGNED;
        end
      end
      fetch_pkg::WAIT_ALIGNED: begin
        if (head_i.valid) begin
          valid_o = 1'b1;
          if (consume) begin
            if (lo_half[1:0] != 2'b11) begin
              state_d = fetch_pkg::WAIT_UNALIGNED;
            end else begin
              pop_o = 1'b1;
            end
          end
        end
      end
      fetch_pkg::WAIT_UNALIGNED: begin
        unaligned = 1'b1;
        if (head_i.valid) begin
          if (hi_half[1:0] != 2'b11) begin
            valid_o = 1'b1;
            if (consume) begin
              pop_o   = 1'b1;
              state_d = fetch_pkg::WAIT_ALIGNED;
            end
          end else if (next_valid_i) begin
            // 32-bit over the word boundary, stays unaligned
            valid_o = 1'b1;
            pop_o   = consume;
          end
        end
      end
      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
    // redirect wins over everything above
    if (redirect_i.valid) begin
      valid_o  = 1'b0;
      pop_o    = 1'b0;
      branch_o = 1'b1;
      state_d  = redirect_i.unaligned ? fetch_pkg::WAIT_UNALIGNED : fetch_pkg::WAIT_ALIGNED;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/prefetch_buffer.sv */
`default_nettype none

module prefetch_buffer #(
  parameter int unsigned DEPTH = 2
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   branch_i,
  input  wire fetch_pkg::addr_t       branch_addr_i,
  input  wire logic                   pop_i,
  output fetch_pkg::fetch_word_t      head_o,
  output logic                        next_valid_o,
  output fetch_pkg::word_t            next_rdata_o,
  output logic                        busy_o,
  output logic                        instr_req_o,
  output fetch_pkg::addr_t            instr_addr_o,
  input  wire logic                   instr_gnt_i,
  input  wire logic                   instr_rvalid_i,
  input  wire fetch_pkg::word_t       instr_rdata_i
);

  localparam int unsigned CW = $clog2(DEPTH + 1);
  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [CW-1:0] cnt_t;
  typedef logic [PW-1:0] ptr_t;

  // wrap-around for any depth, not only powers of two
  function automatic ptr_t ptr_inc(input ptr_t p);
    if (p == ptr_t'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  logic             active_q;
  fetch_pkg::addr_t req_addr_q;
  // target kept aside while an orphaned request still waits for grant
  fetch_pkg::addr_t redir_addr_q;
  logic             redir_pend_q;
  cnt_t             out_cnt_q;
  cnt_t             drop_cnt_q;
  cnt_t             used;
  logic             grant;
  logic             gnt_live;
  logic             gnt_orphan;
  logic             rvalid_live;
  logic             rvalid_drop;

  ////////////////////////////////////////////////////////////
  // word FIFO, tagged with fetch address
  ////////////////////////////////////////////////////////////

  fetch_pkg::addr_t fifo_addr[DEPTH];
  fetch_pkg::word_t fifo_data[DEPTH];
  fetch_pkg::addr_t resp_addr_q;
  cnt_t             fifo_cnt_q;
  ptr_t             rd_ptr_q;
  ptr_t             wr_ptr_q;
  ptr_t             next_ptr;

  // every slot is either in flight, orphaned or stored
  assign used        = out_cnt_q + drop_cnt_q + fifo_cnt_q;
  assign instr_req_o = active_q && (used < cnt_t'(DEPTH));
  assign instr_addr_o = req_addr_q;

  assign grant       = instr_req_o && instr_gnt_i;
  assign gnt_live    = grant && !redir_pend_q;
  assign gnt_orphan  = grant && redir_pend_q;
  // responses to flushed requests come first, in order
  assign rvalid_drop = instr_rvalid_i && (drop_cnt_q != '0);
  assign rvalid_live = instr_rvalid_i && (drop_cnt_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      req_addr_q   <= '0;
      resp_addr_q  <= '0;
      redir_pend_q <= 1'b0;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
      fifo_cnt_q   <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
    end else if (branch_i) begin
      // flush: whatever is still in flight becomes orphaned
      active_q    <= 1'b1;
      resp_addr_q <= branch_addr_i;
      out_cnt_q   <= '0;
      drop_cnt_q  <= drop_cnt_q + out_cnt_q + cnt_t'(grant) - cnt_t'(instr_rvalid_i);
      fifo_cnt_q  <= '0;
      rd_ptr_q    <= '0;
      wr_ptr_q    <= '0;
      if (instr_req_o && !instr_gnt_i) begin
        // bus address must hold until the grant
        redir_pend_q <= 1'b1;
      end else begin
        req_addr_q   <= branch_addr_i;
        redir_pend_q <= 1'b0;
      end
    end else begin
      out_cnt_q  <= out_cnt_q + cnt_t'(gnt_live) - cnt_t'(rvalid_live);
      drop_cnt_q <= drop_cnt_q + cnt_t'(gnt_orphan) - cnt_t'(rvalid_drop);
      fifo_cnt_q <= fifo_cnt_q + cnt_t'(rvalid_live) - cnt_t'(pop_i);
      if (gnt_live) begin
        req_addr_q <= req_addr_q + 32'd4;
      end
      if (gnt_orphan) begin
        req_addr_q   <= redir_addr_q;
        redir_pend_q <= 1'b0;
      end
      if (rvalid_live) begin
        wr_ptr_q    <= ptr_inc(wr_ptr_q);
        resp_addr_q <= resp_addr_q + 32'd4;
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (branch_i) begin
      redir_addr_q <= branch_addr_i;
    end
    if (rvalid_live && !branch_i) begin
      fifo_addr[wr_ptr_q] <= resp_addr_q;
      fifo_data[wr_ptr_q] <= instr_rdata_i;
    end
  end

  // head and the word after it
  assign next_ptr     = ptr_inc(rd_ptr_q);
  assign head_o.valid = (fifo_cnt_q != '0);
  assign head_o.addr  = fifo_addr[rd_ptr_q];
  assign head_o.rdata = fifo_data[rd_ptr_q];
  assign next_valid_o = (fifo_cnt_q >= cnt_t'(2));
  assign next_rdata_o = fifo_data[next_ptr];

  assign busy_o = (out_cnt_q != '0) || (drop_cnt_q != '0);

endmodule

`default_nettype wire

/* verilog/fetch_target_mux.sv */
`default_nettype none

module fetch_target_mux (
  input  wire fetch_pkg::addr_t      boot_addr_i,
  input  wire fetch_pkg::pc_sel_e    pc_sel_i,
  input  wire fetch_pkg::exc_cause_e exc_cause_i,
  input  wire fetch_pkg::addr_t      jump_target_i,
  input  wire fetch_pkg::addr_t      epc_i,
  input  wire logic                  redirect_i,
  output fetch_pkg::redirect_t       target_o
);

  fetch_pkg::addr_t exc_vec;

  // exception vector from boot base and cause
  always_comb begin
    unique case (exc_cause_i)
      fetch_pkg::EXC_ILLINSN: exc_vec = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_ILLINSN};
      fetch_pkg::EXC_IRQ:     exc_vec = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_IRQ};
      fetch_pkg::EXC_IRQ_NM:  exc_vec = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_IRQ_NM};
      default:                exc_vec = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_RESET};
    endcase
  end

  // without a strobe the boot vector is offered, used by the start from IDLE
  always_comb begin
    target_o.valid     = redirect_i;
    target_o.addr      = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_RESET};
    target_o.unaligned = 1'b0;
    if (redirect_i) begin
      unique case (pc_sel_i)
        fetch_pkg::PC_BOOT: begin
          target_o.addr = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_RESET};
        end
        fetch_pkg::PC_JUMP: begin
          // word address plus half-word select
          target_o.addr      = {jump_target_i[31:2], 2'b00};
          target_o.unaligned = jump_target_i[1];
        end
        fetch_pkg::PC_EXCEPTION: begin
          target_o.addr = exc_vec;
        end
        fetch_pkg::PC_ERET: begin
          target_o.addr      = {epc_i[31:2], 2'b00};
          target_o.unaligned = epc_i[1];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // basic widths
  ////////////////////////////////////////////////////////////

  // byte address and fetched word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  // one instruction half, the unit of compressed code
  typedef logic [15:0] half_t;
  // low bits of an exception vector
  typedef logic [4:0]  exc_off_t;

  ////////////////////////////////////////////////////////////
  // redirect selection
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {PC_BOOT, PC_JUMP, PC_EXCEPTION, PC_ERET} pc_sel_e;

  typedef enum logic [1:0] {EXC_RESET, EXC_ILLINSN, EXC_IRQ, EXC_IRQ_NM} exc_cause_e;

  // vector = {boot_addr[31:5], offset}
  parameter exc_off_t EXC_OFF_RESET   = 5'h00;
  parameter exc_off_t EXC_OFF_ILLINSN = 5'h10;
  parameter exc_off_t EXC_OFF_IRQ     = 5'h08;
  parameter exc_off_t EXC_OFF_IRQ_NM  = 5'h0C;

  // alignment tracking inside the fetched word
  typedef enum logic [1:0] {IDLE, WAIT_ALIGNED, WAIT_UNALIGNED} offset_state_e;

  ////////////////////////////////////////////////////////////
  // bundles between the blocks
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  valid;
    addr_t addr;
    logic  unaligned;
  } redirect_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t rdata;
  } fetch_word_t;

  typedef struct packed {
    word_t instr;
    addr_t pc;
    logic  illegal_c;
  } id_instr_t;

endpackage

`default_nettype wire
